// ==== hdl/bb_config.svh ====
`ifndef BB_CONFIG_SVH
`define BB_CONFIG_SVH

// width of each team's running score
`define BB_SCORE_W 8

// action code carried with every play
`define BB_ACTION_W 3

// inning number input, counting from 1
`define BB_INNING_W 2

// game length in innings
`define BB_LAST_INNING 3

// runs on one play, at most a grand slam
`define BB_RUNS_W 3
`define BB_MAX_RUNS 4

`endif

// ==== hdl/bb_pkg.sv ====
`include "bb_config.svh"

package bb_pkg;

  // play codes as sent on the action input
  typedef enum logic [`BB_ACTION_W-1:0] {
    play_walk   = 3'd0,
    play_single = 3'd1,
    play_double = 3'd2,
    play_triple = 3'd3,
    play_homer  = 3'd4,
    play_bunt   = 3'd5,
    play_ground = 3'd6,
    play_fly    = 3'd7
  } play_e;

  // final outcome, guest is team a
  typedef enum logic [1:0] {
    result_guest = 2'd0,
    result_home  = 2'd1,
    result_draw  = 2'd2
  } game_result_e;

  // base occupancy, bit 0 is first base
  // vec for shifting runners, flag for per-base tests
  typedef union packed {
    logic [2:0] vec;
    struct packed {
      logic third;
      logic second;
      logic first;
    } flag;
  } bases_u;

endpackage

// ==== hdl/diamond_tracker.sv ====
`timescale 1ns/1ps

module diamond_tracker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  bb_pkg::play_e  action,
  input  logic           game_over,
  output bb_pkg::bases_u bases,
  output logic [1:0]     outs,
  output logic           side_retired
);

  import bb_pkg::*;

  // runner layout after the play, ignoring a third out
  bases_u     bases_adv;
  // outs charged by this play, 0 to 2
  logic [1:0] outs_add;
  // 3 bits so a double play at one out can reach 3
  logic [2:0] outs_sum;
  logic       third_out;
  logic       two_out;

  assign two_out = (outs == 2'd2);

  always_comb
  begin
    bases_adv = bases;
    outs_add  = 2'd0;
    case (action)
      play_walk:
      begin
        // only forced runners move
        bases_adv.flag.first  = 1'b1;
        bases_adv.flag.second = bases.flag.second | bases.flag.first;
        bases_adv.flag.third  = bases.flag.third | (bases.flag.first & bases.flag.second);
      end
      play_single:
      begin
        if (two_out)
        begin
          // runners go on contact, first to third
          bases_adv.vec = {bases.flag.first, 1'b0, 1'b1};
        end
        else
        begin
          bases_adv.vec = {bases.vec[1:0], 1'b1};
        end
      end
      play_double:
      begin
        if (two_out)
        begin
          bases_adv.vec = 3'b010;
        end
        else
        begin
          bases_adv.vec = {bases.flag.first, 1'b1, 1'b0};
        end
      end
      play_triple:
      begin
        bases_adv.vec = 3'b100;
      end
      play_homer:
      begin
        bases_adv.vec = 3'b000;
      end
      play_bunt:
      begin
        // sacrifice, everyone moves up one
        bases_adv.vec = {bases.vec[1:0], 1'b0};
        outs_add      = 2'd1;
      end
      play_ground:
      begin
        // runner on first doubled off
        bases_adv.vec = {bases.flag.second, 2'b00};
        outs_add      = bases.flag.first ? 2'd2 : 2'd1;
      end
      play_fly:
      begin
        // tag up from third only
        bases_adv.flag.third = 1'b0;
        outs_add             = 2'd1;
      end
      default:
      begin
        bases_adv = bases;
      end
    endcase
  end

  assign outs_sum  = {1'b0, outs} + {1'b0, outs_add};
  assign third_out = (outs_sum > 3'd2);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bases.vec    <= 3'b000;
      outs         <= 2'd0;
      side_retired <= 1'b0;
    end
    else if (game_over)
    begin
      bases.vec    <= 3'b000;
      outs         <= 2'd0;
      side_retired <= 1'b0;
    end
    else
    begin
      // one cycle pulse after the inning half ends
      side_retired <= in_valid & third_out;
      if (in_valid)
      begin
        if (third_out)
        begin
          bases.vec <= 3'b000;
          outs      <= 2'd0;
        end
        else
        begin
          bases <= bases_adv;
          outs  <= outs_sum[1:0];
        end
      end
    end
  end

  // third out must wrap to zero at the same edge
  outs_never_three: assert property (@(posedge clk) disable iff (!rst_n) outs != 2'd3);

endmodule

// ==== hdl/run_scorer.sv ====
`timescale 1ns/1ps
`include "bb_config.svh"

module run_scorer (
  input  bb_pkg::play_e          action,
  input  bb_pkg::bases_u         bases,
  input  logic [1:0]             outs,
  output logic [`BB_RUNS_W-1:0]  runs
);

  import bb_pkg::*;

  logic                  two_out;
  logic                  loaded;
  // runners currently on base
  logic [`BB_RUNS_W-1:0] on_base;
  // runners on second and third
  logic [`BB_RUNS_W-1:0] in_scoring;
  logic [`BB_RUNS_W-1:0] from_third;

  // widen one flag to a run count
  function automatic logic [`BB_RUNS_W-1:0] one_run(input logic flag);
    one_run = {{(`BB_RUNS_W-1){1'b0}}, flag};
  endfunction

  assign two_out    = (outs == 2'd2);
  assign loaded     = &bases.vec;
  assign from_third = one_run(bases.flag.third);
  assign in_scoring = one_run(bases.vec[2]) + one_run(bases.vec[1]);
  assign on_base    = in_scoring + one_run(bases.vec[0]);

  always_comb
  begin
    runs = '0;
    case (action)
      play_walk:
      begin
        // forced in only with the bases full
        runs = one_run(loaded);
      end
      play_single:
      begin
        // with two out second base also scores
        runs = two_out ? in_scoring : from_third;
      end
      play_double:
      begin
        runs = two_out ? on_base : in_scoring;
      end
      play_triple:
      begin
        runs = on_base;
      end
      play_homer:
      begin
        // batter scores too
        runs = on_base + one_run(1'b1);
      end
      play_bunt:
      begin
        runs = from_third;
      end
      play_ground:
      begin
        // double play at one out or a third out kills the run
        if (outs == 2'd0 || (outs == 2'd1 && !bases.flag.first))
        begin
          runs = from_third;
        end
      end
      play_fly:
      begin
        if (!two_out)
        begin
          runs = from_third;
        end
      end
      default:
      begin
        runs = '0;
      end
    endcase
  end

  // grand slam is the ceiling
  runs_in_range: assert final (runs <= `BB_RUNS_W'(`BB_MAX_RUNS));

endmodule

// ==== hdl/scoreboard.sv ====
`timescale 1ns/1ps
`include "bb_config.svh"

module scoreboard (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  logic [`BB_INNING_W-1:0] inning,
  input  logic                    half,
  input  logic [`BB_RUNS_W-1:0]   runs,
  input  logic                    side_retired,
  output logic                    game_over,
  output logic                    out_valid,
  output logic [`BB_SCORE_W-1:0]  score_a,
  output logic [`BB_SCORE_W-1:0]  score_b,
  output bb_pkg::game_result_e    result
);

  import bb_pkg::*;

  localparam logic [`BB_INNING_W-1:0] last_inning = `BB_LAST_INNING;

  // inning and half of the most recent play
  logic                    play_half;
  logic [`BB_INNING_W-1:0] play_inning;
  // home already ahead after the top of the last inning
  logic                    home_lock;
  logic                    lock_now;
  logic                    last_retired;
  logic [`BB_SCORE_W-1:0]  runs_ext;

  assign runs_ext     = {{(`BB_SCORE_W-`BB_RUNS_W){1'b0}}, runs};
  assign last_retired = side_retired && (play_inning == last_inning);
  // game ends with the third out of the bottom half
  assign out_valid    = last_retired && play_half;
  assign game_over    = out_valid;
  // a bottom half play may land in the very cycle the top half closes
  assign lock_now     = home_lock || (last_retired && !play_half && (score_b > score_a));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play_half   <= 1'b0;
      play_inning <= '0;
    end
    else if (in_valid)
    begin
      play_half   <= half;
      play_inning <= inning;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      score_a   <= '0;
      score_b   <= '0;
      home_lock <= 1'b0;
    end
    else if (game_over)
    begin
      score_a   <= '0;
      score_b   <= '0;
      home_lock <= 1'b0;
    end
    else
    begin
      home_lock <= lock_now;
      if (in_valid && !half)
      begin
        score_a <= score_a + runs_ext;
      end
      else if (in_valid && !lock_now)
      begin
        score_b <= score_b + runs_ext;
      end
    end
  end

  // full width compare
  always_comb
  begin
    if (score_a > score_b)
      result = result_guest;
    else if (score_b > score_a)
      result = result_home;
    else
      result = result_draw;
  end

  // game end is a single pulse, scores clear behind it
  out_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid);

endmodule

// ==== hdl/bb_top.sv ====
`timescale 1ns/1ps
`include "bb_config.svh"

module bb_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  logic [`BB_INNING_W-1:0] inning,
  input  logic                    half,
  input  bb_pkg::play_e           action,
  output logic                    out_valid,
  output logic [`BB_SCORE_W-1:0]  score_a,
  output logic [`BB_SCORE_W-1:0]  score_b,
  output bb_pkg::game_result_e    result
);

  import bb_pkg::*;

  // runner and out state seen by the scorer
  bases_u                bases;
  logic [1:0]            outs;
  logic                  side_retired;
  logic [`BB_RUNS_W-1:0] runs;
  // clears the diamond at game end
  logic                  game_over;

  diamond_tracker diamond_tracker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .action       (action),
    .game_over    (game_over),
    .bases        (bases),
    .outs         (outs),
    .side_retired (side_retired)
  );

  // same play and same situation as the tracker
  run_scorer run_scorer_inst (
    .action (action),
    .bases  (bases),
    .outs   (outs),
    .runs   (runs)
  );

  scoreboard scoreboard_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .inning       (inning),
    .half         (half),
    .runs         (runs),
    .side_retired (side_retired),
    .game_over    (game_over),
    .out_valid    (out_valid),
    .score_a      (score_a),
    .score_b      (score_b),
    .result       (result)
  );

endmodule

// ==== test/bb_checker.sv ====
`timescale 1ns/1ps
`include "bb_config.svh"

module bb_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic                   out_valid,
  input  logic [`BB_SCORE_W-1:0] score_a,
  input  logic [`BB_SCORE_W-1:0] score_b,
  input  bb_pkg::game_result_e   result,
  input  logic                   exp_valid,
  input  logic [`BB_SCORE_W-1:0] exp_a,
  input  logic [`BB_SCORE_W-1:0] exp_b,
  input  logic [1:0]             exp_result,
  input  logic                   missed,
  input  logic                   report,
  output int                     passed,
  output int                     failed
);

  import bb_pkg::*;

  localparam int sw = `BB_SCORE_W;

  // pending finals packed as score_a, score_b and result
  logic [2*sw+1:0] expect_q[$];
  logic [2*sw+1:0] cur;
  // out_valid seen at the previous edge
  logic            was_valid;
  // play taken at the previous edge
  logic            was_play;
  int              game_no;
  int              errs;

  // prints an error line and returns 1 on a wrong value
  function automatic int field_mismatch(input string name, input logic [31:0] expected,
                                        input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, expected, actual);
      return 1;
    end
    return 0;
  endfunction

  initial
  begin
    passed  = 0;
    failed  = 0;
    game_no = 0;
  end

  // sampled at the rising edge before the DUT registers move
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      was_valid = 1'b0;
      was_play  = 1'b0;
    end
    else
    begin
      if (exp_valid)
        expect_q.push_back({exp_a, exp_b, exp_result});
      // single pulse with the scores back at zero behind it
      if (was_valid && (out_valid || score_a != '0 || score_b != '0))
      begin
        $display("game %0d did not clear out_valid and the scores after its end", game_no);
        failed++;
      end
      if ((out_valid || missed) && expect_q.size() == 0)
      begin
        $display("out_valid came while no game was expected to end");
        failed++;
      end
      else if (out_valid || missed)
      begin
        game_no++;
        cur = expect_q.pop_front();
        if (missed)
        begin
          $display("game %0d fail, the game never raised out_valid", game_no);
          failed++;
        end
        else
        begin
          errs = 0;
          // game end belongs in the cycle right after the final play
          if (!was_play)
          begin
            $display("game %0d raised out_valid later than one cycle after the last play",
                     game_no);
            errs = 1;
          end
          errs += field_mismatch("score_a", cur[2*sw+1:sw+2], score_a);
          errs += field_mismatch("score_b", cur[sw+1:2], score_b);
          errs += field_mismatch("result", cur[1:0], result);
          if (errs == 0)
          begin
            passed++;
            $display("game %0d pass with %0d to %0d", game_no, score_a, score_b);
          end
          else
          begin
            failed++;
            $display("game %0d fail with %0d errors", game_no, errs);
          end
        end
      end
      was_valid = out_valid;
      was_play  = in_valid;
    end
  end

  always @(posedge report)
    $display("games passed %0d failed %0d", passed, failed);

endmodule

// ==== test/bb_tb.sv ====
`timescale 1ns/1ps
`include "bb_config.svh"

module bb_tb;

  import bb_pkg::*;

  localparam int reset_cycles    = 16;
  localparam int cycles_per_play = 40;

  logic                    clk;
  logic                    rst_n;
  logic                    in_valid;
  logic [`BB_INNING_W-1:0] inning;
  logic                    half;
  play_e                   action;
  logic                    out_valid;
  logic [`BB_SCORE_W-1:0]  score_a;
  logic [`BB_SCORE_W-1:0]  score_b;
  game_result_e            result;
  // expected final handed to the checker
  logic                    exp_valid;
  logic [`BB_SCORE_W-1:0]  exp_a;
  logic [`BB_SCORE_W-1:0]  exp_b;
  logic [1:0]              exp_result;
  // no game end seen for this game
  logic                    missed;
  logic                    report;
  int                      passed;
  int                      failed;
  // kind 0 is a play and kind 1 a final score
  int                      ent_kind[$];
  int                      ent_x[$];
  int                      ent_y[$];
  int                      ent_z[$];
  int                      play_count;
  int                      game_count;
  int                      idx;

  bb_top bb_top_inst (.*);

  bb_checker bb_checker_inst (.*);

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // groups of four numbers, lines starting with # are skipped
  task automatic load_cases();
    int fd;
    int n;
    int kind;
    int x;
    int y;
    int z;
    logic [8*128-1:0] line;
    fd = $fopen("test/bb_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open test/bb_cases.txt so no games are played");
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fscanf(fd, "%d %d %d %d", kind, x, y, z);
        if (n == 4)
        begin
          ent_kind.push_back(kind);
          ent_x.push_back(x);
          ent_y.push_back(y);
          ent_z.push_back(z);
          play_count += (kind == 0);
          game_count += (kind == 1);
        end
        else
        begin
          // comment text up to end of line
          n = $fgets(line, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  // one play after an idle gap of 0 to 3 cycles
  task automatic send_play(input int inn, input int hlf, input int act);
    int gap;
    gap = $urandom % 4;
    repeat (gap) @(negedge clk);
    inning   = inn[`BB_INNING_W-1:0];
    half     = hlf[0];
    action   = play_e'(act[`BB_ACTION_W-1:0]);
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // queue the final, then wait out the game end pulse
  task automatic expect_final(input int a, input int b, input int r);
    int waited;
    exp_a      = a[`BB_SCORE_W-1:0];
    exp_b      = b[`BB_SCORE_W-1:0];
    exp_result = r[1:0];
    exp_valid  = 1'b1;
    waited     = 0;
    // normally already high one cycle after the last play
    while (!out_valid && waited < 4)
    begin
      @(negedge clk);
      exp_valid = 1'b0;
      waited++;
    end
    missed = !out_valid;
    @(negedge clk);
    exp_valid = 1'b0;
    missed    = 1'b0;
  endtask

  initial
  begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    inning     = '0;
    half       = 1'b0;
    action     = play_walk;
    exp_valid  = 1'b0;
    exp_a      = '0;
    exp_b      = '0;
    exp_result = '0;
    missed     = 1'b0;
    report     = 1'b0;
    play_count = 0;
    game_count = 0;
    void'($urandom(13901));
    load_cases();
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    for (idx = 0; idx < ent_kind.size(); idx++)
    begin
      if (ent_kind[idx] == 0)
        send_play(ent_x[idx], ent_y[idx], ent_z[idx]);
      else
        expect_final(ent_x[idx], ent_y[idx], ent_z[idx]);
    end
    // room for the clear check after the last final
    repeat (2) @(negedge clk);
    report = 1'b1;
    #1;
    if (game_count > 0 && failed == 0 && passed == game_count)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // reset release comes after the cases are loaded
  initial
  begin
    wait (rst_n === 1'b1);
    #((play_count * cycles_per_play + 4 * reset_cycles) * 10);
    $display("watchdog expired, the games did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== test/bb_cases.txt ====
# groups of four numbers, a play is 0 inning half action
# actions are walk 0 single 1 double 2 triple 3 homer 4 bunt 5 ground 6 fly 7
# a final is 1 score_a score_b result with guest 0 home 1 draw 2
# game 1 guest wins 11 to 5 with walks, hits, a grand slam, bunts and double plays
0 1 0 0  0 1 0 0  0 1 0 0  0 1 0 0  0 1 0 7  0 1 0 1  0 1 0 6
0 1 1 2  0 1 1 1  0 1 1 1  0 1 1 7  0 1 1 7  0 1 1 1  0 1 1 2  0 1 1 7
0 2 0 1  0 2 0 1  0 2 0 3  0 2 0 4  0 2 0 0  0 2 0 0
0 2 0 0  0 2 0 4  0 2 0 7  0 2 0 7  0 2 0 7
0 2 1 1  0 2 1 5  0 2 1 1  0 2 1 6
0 3 0 2  0 3 0 6  0 3 0 6  0 3 0 7
0 3 1 3  0 3 1 5  0 3 1 0  0 3 1 6
1 11 5 0
# game 2 home leads after the top of the 3rd so its late homers do not count
0 1 0 7  0 1 0 7  0 1 0 7
0 1 1 4  0 1 1 7  0 1 1 7  0 1 1 7
0 2 0 7  0 2 0 7  0 2 0 7
0 2 1 7  0 2 1 7  0 2 1 7
0 3 0 7  0 3 0 7  0 3 0 7
0 3 1 4  0 3 1 4  0 3 1 7  0 3 1 7  0 3 1 7
1 0 1 1
# game 3 ends level after a run scores on a ground ball double play
0 1 0 0  0 1 0 1  0 1 0 1  0 1 0 6  0 1 0 7
0 1 1 4  0 1 1 7  0 1 1 7  0 1 1 7
0 2 0 7  0 2 0 7  0 2 0 7
0 2 1 7  0 2 1 7  0 2 1 7
0 3 0 7  0 3 0 7  0 3 0 7
0 3 1 7  0 3 1 7  0 3 1 7
1 1 1 2

// ==== bb.f ====
+incdir+hdl
hdl/bb_pkg.sv
hdl/diamond_tracker.sv
hdl/run_scorer.sv
hdl/scoreboard.sv
hdl/bb_top.sv
test/bb_checker.sv
test/bb_tb.sv

// ==== Bender.yml ====
package:
  name: bb

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/bb_pkg.sv
      - hdl/diamond_tracker.sv
      - hdl/run_scorer.sv
      - hdl/scoreboard.sv
      - hdl/bb_top.sv
  - target: test
    files:
      - test/bb_checker.sv
      - test/bb_tb.sv
